/* filelist.f */
+incdir+rtl
rtl/waveform_pkg.sv
rtl/spi_command_slave.sv
rtl/control_registers.sv
rtl/waveform_memory.sv
rtl/playback_sequencer.sv
rtl/waveform_generator_top.sv
test/waveform_generator_checker.sv
test/waveform_generator_tb.sv

/* test/waveform_generator_tb.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module waveform_generator_tb;
	localparam int FRAME_GAP = 16;
	// select setup, 56 bits of 8 clocks, idle gap
	localparam int FRAME_CLOCKS = 8 * `SPI_FRAME_BITS + FRAME_GAP + 8;
	localparam int MEM_WORDS = 16;
	// window 4w+1 to 4w+23 with w = 2
	localparam int PLAY_START = 9;
	localparam int PLAY_END = 31;
	localparam int PASS_LENGTH = PLAY_END - PLAY_START;
	localparam int SYNC_WAIT = 2 * FRAME_CLOCKS;
	localparam int QUIET_CLOCKS = 100;
	// 33 memory, 8 register, 4 playback, 2 pass count, 5 abort, 2 disable
	localparam int FRAME_COUNT = 54;
	localparam int PLAY_CLOCKS = 3 * PASS_LENGTH + 4 + QUIET_CLOCKS + 2 * SYNC_WAIT;
	localparam int WATCHDOG_CYCLES = 2 * (16 + FRAME_COUNT * FRAME_CLOCKS + PLAY_CLOCKS);
	localparam logic [31:0] BYTE_ADDR_MASK = (1 << `WAVE_BYTE_ADDR_WIDTH) - 1;

	logic word_clock, reset4_word_clock, sck, mosi, ssel;
	logic miso, sync;
	logic [`WAVE_SAMPLE_WIDTH-1:0] sample;

	logic [31:0] model_mem [0:MEM_WORDS-1];
	integer seed = 32'hb935;
	int error_count = 0;
	int test_count = 0;
	int failed_tests = 0;
	int test_start_errors = 0;
	int sync_total = 0;
	// compare process control
	logic compare_go = 1'b0;
	logic compare_done = 1'b0;
	logic compare_quiet = 1'b0;
	int compare_length = 0;
	string compare_name = "";

	waveform_generator_top uut (
		.word_clock(word_clock),
		.reset4_word_clock(reset4_word_clock),
		.sck(sck),
		.mosi(mosi),
		.ssel(ssel),
		.miso(miso),
		.sample(sample),
		.sync(sync)
	);

	bind waveform_generator_top waveform_generator_checker protocol_checks (
		.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.cmd_req(cmd_req), .cmd_ack(cmd_ack), .playback_enable(playback_enable),
		.sample(sample), .sync(sync));

	initial begin
		word_clock = 1'b0;
		forever #5 word_clock = ~word_clock;
	end

	// ------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------

	// empty or inverted range plays start alone
	function automatic int pass_length(input int start, input int stop);
		return (stop > start) ? stop - start : 1;
	endfunction

	// nth byte of playback, byte k of word w at 4w+k
	function automatic logic [7:0] expected_sample(input int start, input int stop, input int n);
		int address;
		logic [31:0] word;
		address = start + n % pass_length(start, stop);
		word = model_mem[address / 4];
		return word[(address % 4) * 8 +: 8];
	endfunction

	// ------------------------------------------------------------------
	// spi master, mode 0, msb first
	// ------------------------------------------------------------------

	task automatic spi_transfer(input logic [7:0] opcode, input logic [15:0] address,
		input logic [31:0] data, input int bits, output logic [31:0] reply);
		logic [`SPI_FRAME_BITS-1:0] frame;
		frame = {opcode, address, data};
		reply = '0;
		@(posedge word_clock);
		ssel <= 1'b0;
		for (int i = 0; i < bits; i++) begin
			// mosi set up while sck low
			@(posedge word_clock);
			sck <= 1'b0;
			mosi <= frame[`SPI_FRAME_BITS - 1 - i];
			repeat (3) @(posedge word_clock);
			// miso sampled just before the rising edge, data phase only
			@(negedge word_clock);
			if (i >= `SPI_FRAME_BITS - `SPI_DATA_BITS) begin
				reply = {reply[30:0], miso};
			end
			@(posedge word_clock);
			sck <= 1'b1;
			repeat (3) @(posedge word_clock);
		end
		@(posedge word_clock);
		sck <= 1'b0;
		repeat (4) @(posedge word_clock);
		ssel <= 1'b1;
		repeat (FRAME_GAP) @(posedge word_clock);
	endtask

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		if (error_count == test_start_errors) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: %0d errors", name, error_count - test_start_errors);
		end
		test_start_errors = error_count;
	endtask

	task automatic start_compare(input string name, input logic quiet, input int length);
		compare_name = name;
		compare_quiet = quiet;
		compare_length = length;
		compare_done = 1'b0;
		compare_go = 1'b1;
	endtask

	task automatic wait_compare();
		while (!compare_done) @(posedge word_clock);
	endtask

	// ------------------------------------------------------------------
	// sample and sync compare, all at the falling edge
	// ------------------------------------------------------------------

	always @(negedge word_clock) begin
		if (sync === 1'b1) begin
			sync_total = sync_total + 1;
		end
	end

	initial begin : compare_process
		logic [7:0] expected;
		logic expected_sync;
		int waited;
		forever begin
			@(negedge word_clock);
			if (compare_go) begin
				compare_go = 1'b0;
				if (compare_quiet) begin
					for (int n = 0; n < compare_length; n++) begin
						if (sample !== 8'h00 || sync !== 1'b0) begin
							$display("ERROR %s cycle %0d: expected 00/0, actual %h/%b",
								compare_name, n, sample, sync);
							error_count++;
						end
						@(negedge word_clock);
					end
				end else begin
					// the pass starts at the first sync
					waited = 0;
					while (sync !== 1'b1 && waited < SYNC_WAIT) begin
						@(negedge word_clock);
						waited++;
					end
					if (sync !== 1'b1) begin
						$display("%s: no sync pulse after enabling playback", compare_name);
						error_count++;
					end else begin
						for (int n = 0; n < compare_length; n++) begin
							expected = expected_sample(PLAY_START, PLAY_END, n);
							expected_sync = (n % pass_length(PLAY_START, PLAY_END) == 0);
							if (sample !== expected) begin
								$display("ERROR %s sample %0d: expected %h, actual %h",
									compare_name, n, expected, sample);
								error_count++;
							end
							if (sync !== expected_sync) begin
								$display("ERROR %s sync %0d: expected %b, actual %b",
									compare_name, n, expected_sync, sync);
								error_count++;
							end
							@(negedge word_clock);
						end
					end
				end
				compare_done = 1'b1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge word_clock);
		$display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------

	initial begin : main_flow
		logic [31:0] reply;
		int pass_base, passes, low, high, sync_base;
		reset4_word_clock = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		ssel = 1'b1;
		repeat (16) @(posedge word_clock);
		reset4_word_clock <= 1'b0;
		repeat (4) @(posedge word_clock);

		// memory write then readback, reply lags one frame
		for (int i = 0; i < MEM_WORDS; i++) begin
			model_mem[i] = $random(seed);
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			spi_transfer(waveform_pkg::cmd_write_mem, i, model_mem[i], 56, reply);
		end
		spi_transfer(waveform_pkg::cmd_read_mem, 0, 0, 56, reply);
		for (int i = 1; i <= MEM_WORDS; i++) begin
			spi_transfer((i < MEM_WORDS) ? waveform_pkg::cmd_read_mem : 8'h00, i, 0, 56, reply);
			compare_word("memory_readback", model_mem[i-1], reply);
		end
		report_test("memory_readback");

		// register bank, upper bits dropped by width
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_START, 32'hffff_f004, 56, reply);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_END, 32'h5555_5010, 56, reply);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_ENABLE, 32'h7777_7771, 56, reply);
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_START, 0, 56, reply);
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_END, 0, 56, reply);
		compare_word("register_readback", 32'hffff_f004 & BYTE_ADDR_MASK, reply);
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_ENABLE, 0, 56, reply);
		compare_word("register_readback", 32'h5555_5010 & BYTE_ADDR_MASK, reply);
		spi_transfer(8'h00, 0, 0, 56, reply);
		compare_word("register_readback", 32'h1, reply);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_ENABLE, 0, 56, reply);
		report_test("register_readback");

		// playback over two passes, pass count frozen while disabled
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_PASS_COUNT, 0, 56, reply);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_START, PLAY_START, 56, reply);
		pass_base = reply;
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_END, PLAY_END, 56, reply);
		sync_base = sync_total;
		start_compare("playback", 1'b0, 2 * PASS_LENGTH);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_ENABLE, 1, 56, reply);
		wait_compare();
		report_test("playback");

		// first sync after enable has no wrap behind it
		passes = sync_total - sync_base - 1;
		low = pass_base + passes;
		high = low + FRAME_CLOCKS / PASS_LENGTH + 2;
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_PASS_COUNT, 0, 56, reply);
		spi_transfer(8'h00, 0, 0, 56, reply);
		if (reply < low || reply > high) begin
			$display("ERROR pass_count: expected %0d to %0d, actual %0d", low, high, reply);
			error_count++;
		end
		report_test("pass_count");

		// 40 bit frames are dropped
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_START, 32'h777, 40, reply);
		spi_transfer(waveform_pkg::cmd_write_mem, 3, ~model_mem[3], 40, reply);
		spi_transfer(waveform_pkg::cmd_read_reg, `REG_START, 0, 56, reply);
		spi_transfer(waveform_pkg::cmd_read_mem, 3, 0, 56, reply);
		compare_word("aborted_frame", PLAY_START, reply);
		spi_transfer(8'h00, 0, 0, 56, reply);
		compare_word("aborted_frame", model_mem[3], reply);
		report_test("aborted_frame");

		// silent while disabled, then restart from start with a sync
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_ENABLE, 0, 56, reply);
		start_compare("disable", 1'b1, QUIET_CLOCKS);
		wait_compare();
		start_compare("reenable", 1'b0, PASS_LENGTH + 4);
		spi_transfer(waveform_pkg::cmd_write_reg, `REG_ENABLE, 1, 56, reply);
		wait_compare();
		report_test("disable");

		if (uut.protocol_checks.failure_count != 0) begin
			$display("protocol checker reported %0d assertion failures",
				uut.protocol_checks.failure_count);
			error_count += uut.protocol_checks.failure_count;
		end
		$display("tests %0d, failed tests %0d, errors %0d", test_count, failed_tests, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* test/waveform_generator_checker.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module waveform_generator_checker (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic cmd_req,
	input logic cmd_ack,
	input logic playback_enable,
	input logic [`WAVE_SAMPLE_WIDTH-1:0] sample,
	input logic sync
);
	// number of failed assertions so far
	int failure_count = 0;

	// ------------------------------------------------------------------
	// spi slave to register block handshake
	// ------------------------------------------------------------------

	// ack only answers a pending request
	ack_needs_req: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		$rose(cmd_ack) |-> cmd_req)
	else begin
		failure_count++;
		$error("cmd_ack rose while cmd_req was low");
	end

	// request stays up until acked
	req_held: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		cmd_req && !cmd_ack |=> cmd_req)
	else begin
		failure_count++;
		$error("cmd_req dropped before cmd_ack");
	end

	// ------------------------------------------------------------------
	// playback outputs
	// ------------------------------------------------------------------

	// single cycle pulse per pass
	sync_single: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		sync |=> !sync)
	else begin
		failure_count++;
		$error("sync was high for more than one cycle");
	end

	// silent while disabled and on the first enabled cycle
	// no stale pipe byte may leak out on re-enable
	quiet_disabled: assert property (@(posedge word_clock) disable iff (reset4_word_clock)
		(!playback_enable || !$past(playback_enable)) |-> sample == '0 && !sync)
	else begin
		failure_count++;
		$error("sample or sync active while playback disabled or just enabled");
	end

endmodule

/* rtl/waveform_generator_top.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module waveform_generator_top (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic sck,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output logic [`WAVE_SAMPLE_WIDTH-1:0] sample,
	output logic sync
);
	// spi slave to register block
	logic cmd_req, cmd_ack;
	waveform_pkg::command_t cmd_opcode;
	logic [`SPI_ADDRESS_BITS-1:0] cmd_address;
	logic [`SPI_DATA_BITS-1:0] cmd_data, reply_data;
	// host side of the memory
	logic [`WAVE_WORD_ADDR_WIDTH-1:0] host_address;
	logic [`WAVE_WORD_WIDTH-1:0] host_write_data, host_read_data;
	logic host_write_enable;
	// playback settings and status
	logic [`WAVE_BYTE_ADDR_WIDTH-1:0] start_address, end_address, play_address;
	logic playback_enable;
	logic [31:0] pass_count;
	logic [`WAVE_SAMPLE_WIDTH-1:0] play_byte;

	spi_command_slave spi (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.sck(sck), .mosi(mosi), .ssel(ssel), .miso(miso),
		.cmd_req(cmd_req), .cmd_opcode(cmd_opcode), .cmd_address(cmd_address),
		.cmd_data(cmd_data), .cmd_ack(cmd_ack), .reply_data(reply_data));

	control_registers regs (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.cmd_req(cmd_req), .cmd_opcode(cmd_opcode), .cmd_address(cmd_address),
		.cmd_data(cmd_data), .cmd_ack(cmd_ack), .reply_data(reply_data),
		.host_address(host_address), .host_write_data(host_write_data),
		.host_write_enable(host_write_enable), .host_read_data(host_read_data),
		.start_address(start_address), .end_address(end_address),
		.playback_enable(playback_enable), .pass_count(pass_count));

	waveform_memory mem (.word_clock(word_clock),
		.host_address(host_address), .host_write_data(host_write_data),
		.host_write_enable(host_write_enable), .host_read_data(host_read_data),
		.play_address(play_address), .play_byte(play_byte));

	playback_sequencer seq (.word_clock(word_clock), .reset4_word_clock(reset4_word_clock),
		.start_address(start_address), .end_address(end_address),
		.playback_enable(playback_enable), .play_address(play_address),
		.play_byte(play_byte), .sample(sample), .sync(sync), .pass_count(pass_count));

endmodule

/* rtl/playback_sequencer.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module playback_sequencer (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic [`WAVE_BYTE_ADDR_WIDTH-1:0] start_address,
	input logic [`WAVE_BYTE_ADDR_WIDTH-1:0] end_address,
	input logic playback_enable,
	output logic [`WAVE_BYTE_ADDR_WIDTH-1:0] play_address,
	input logic [`WAVE_SAMPLE_WIDTH-1:0] play_byte,
	output logic [`WAVE_SAMPLE_WIDTH-1:0] sample,
	output logic sync,
	output logic [31:0] pass_count
);
	waveform_pkg::sequencer_state_t state;
	logic [`WAVE_BYTE_ADDR_WIDTH-1:0] last_address, last_next;
	logic pass_first, issue_valid, byte_valid, byte_first, sync_q;
	logic [`WAVE_SAMPLE_WIDTH-1:0] sample_q;

	// end is exclusive, empty range plays start alone
	assign last_next = (end_address > start_address) ? end_address - 1'b1 : start_address;
	assign issue_valid = (state == waveform_pkg::seq_playing) && playback_enable;

	// ------------------------------------------------------------------
	// address stepper
	// ------------------------------------------------------------------

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			state <= waveform_pkg::seq_stopped;
			play_address <= '0;
			last_address <= '0;
			pass_first <= 1'b0;
			pass_count <= '0;
		end else if (state == waveform_pkg::seq_stopped || !playback_enable) begin
			// park on start until enabled
			state <= playback_enable ? waveform_pkg::seq_playing : waveform_pkg::seq_stopped;
			play_address <= start_address;
			last_address <= last_next;
			pass_first <= 1'b1;
		end else if (play_address == last_address) begin
			// wrap, range sampled again here
			play_address <= start_address;
			last_address <= last_next;
			pass_first <= 1'b1;
			pass_count <= pass_count + 1'b1;
		end else begin
			play_address <= play_address + 1'b1;
			pass_first <= 1'b0;
		end
	end

	// two stage output pipe, ram then sample register
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			byte_valid <= 1'b0;
			byte_first <= 1'b0;
			sample_q <= '0;
			sync_q <= 1'b0;
		end else begin
			byte_valid <= issue_valid;
			byte_first <= issue_valid && pass_first;
			sample_q <= byte_valid ? play_byte : '0;
			sync_q <= byte_first;
		end
	end

	// silent as soon as enable drops
	assign sample = playback_enable ? sample_q : '0;
	assign sync = playback_enable && sync_q;

endmodule

/* rtl/waveform_memory.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module waveform_memory (
	input logic word_clock,
	input logic [`WAVE_WORD_ADDR_WIDTH-1:0] host_address,
	input logic [`WAVE_WORD_WIDTH-1:0] host_write_data,
	input logic host_write_enable,
	output logic [`WAVE_WORD_WIDTH-1:0] host_read_data,
	input logic [`WAVE_BYTE_ADDR_WIDTH-1:0] play_address,
	output logic [`WAVE_SAMPLE_WIDTH-1:0] play_byte
);
	localparam int DEPTH = 1 << `WAVE_WORD_ADDR_WIDTH;
	localparam int LANE_BITS = `WAVE_BYTE_ADDR_WIDTH - `WAVE_WORD_ADDR_WIDTH;

	logic [`WAVE_WORD_WIDTH-1:0] mem [0:DEPTH-1];
	logic [`WAVE_WORD_WIDTH-1:0] play_word;
	logic [LANE_BITS-1:0] lane_select;

	// ------------------------------------------------------------------
	// host port, 32 bit read/write
	// ------------------------------------------------------------------

	// read returns the old word on a write cycle
	always_ff @(posedge word_clock) begin
		if (host_write_enable) begin
			mem[host_address] <= host_write_data;
		end
		host_read_data <= mem[host_address];
	end

	// ------------------------------------------------------------------
	// playback port, byte wide
	// ------------------------------------------------------------------

	// word index from the upper byte address bits
	always_ff @(posedge word_clock) begin
		play_word <= mem[play_address[`WAVE_BYTE_ADDR_WIDTH-1:LANE_BITS]];
		lane_select <= play_address[LANE_BITS-1:0];
	end

	// byte k is bits 8k+7 down to 8k
	assign play_byte = play_word[lane_select*`WAVE_SAMPLE_WIDTH +: `WAVE_SAMPLE_WIDTH];

endmodule

/* rtl/control_registers.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module control_registers (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic cmd_req,
	input waveform_pkg::command_t cmd_opcode,
	input logic [`SPI_ADDRESS_BITS-1:0] cmd_address,
	input logic [`SPI_DATA_BITS-1:0] cmd_data,
	output logic cmd_ack,
	output logic [`SPI_DATA_BITS-1:0] reply_data,
	output logic [`WAVE_WORD_ADDR_WIDTH-1:0] host_address,
	output logic [`WAVE_WORD_WIDTH-1:0] host_write_data,
	output logic host_write_enable,
	input logic [`WAVE_WORD_WIDTH-1:0] host_read_data,
	output logic [`WAVE_BYTE_ADDR_WIDTH-1:0] start_address,
	output logic [`WAVE_BYTE_ADDR_WIDTH-1:0] end_address,
	output logic playback_enable,
	input logic [31:0] pass_count
);
	logic new_request, read_wait, reg_write, reg_in_range;
	logic [`SPI_DATA_BITS-1:0] reg_readback;

	// memory host port follows the held command
	assign host_address = cmd_address[`WAVE_WORD_ADDR_WIDTH-1:0];
	assign host_write_data = cmd_data;

	// one action per request
	assign new_request = cmd_req && !cmd_ack && !read_wait;
	// index 4 and up reads as zero
	assign reg_in_range = (cmd_address[`SPI_ADDRESS_BITS-1:2] == '0);

	always_comb begin
		reg_readback = '0;
		if (reg_in_range) begin
			case (cmd_address[1:0])
				`REG_START: reg_readback = {{(`SPI_DATA_BITS-`WAVE_BYTE_ADDR_WIDTH){1'b0}},
					start_address};
				`REG_END: reg_readback = {{(`SPI_DATA_BITS-`WAVE_BYTE_ADDR_WIDTH){1'b0}},
					end_address};
				`REG_ENABLE: reg_readback = {{(`SPI_DATA_BITS-1){1'b0}}, playback_enable};
				default: reg_readback = pass_count;
			endcase
		end
	end

	// ------------------------------------------------------------------
	// command execution
	// ------------------------------------------------------------------

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			cmd_ack <= 1'b0;
			reply_data <= '0;
			read_wait <= 1'b0;
			reg_write <= 1'b0;
			host_write_enable <= 1'b0;
			start_address <= '0;
			end_address <= '0;
			playback_enable <= 1'b0;
		end else begin
			read_wait <= 1'b0;
			reg_write <= 1'b0;
			host_write_enable <= 1'b0;
			if (new_request) begin
				reply_data <= '0;
				case (cmd_opcode)
					waveform_pkg::cmd_write_reg: reg_write <= 1'b1;
					waveform_pkg::cmd_read_reg: reply_data <= reg_readback;
					waveform_pkg::cmd_write_mem: host_write_enable <= 1'b1;
					default: ;
				endcase
				// memory read acks after the ram latency
				if (cmd_opcode == waveform_pkg::cmd_read_mem) begin
					read_wait <= 1'b1;
				end else begin
					cmd_ack <= 1'b1;
				end
			end
			if (read_wait) begin
				reply_data <= host_read_data;
				cmd_ack <= 1'b1;
			end
			// lands one cycle after ack, same as a memory write
			if (reg_write && reg_in_range) begin
				case (cmd_address[1:0])
					`REG_START: start_address <= cmd_data[`WAVE_BYTE_ADDR_WIDTH-1:0];
					`REG_END: end_address <= cmd_data[`WAVE_BYTE_ADDR_WIDTH-1:0];
					`REG_ENABLE: playback_enable <= cmd_data[0];
					// pass count is read only
					default: ;
				endcase
			end
			if (cmd_ack && !cmd_req) begin
				cmd_ack <= 1'b0;
			end
		end
	end

endmodule

/* rtl/spi_command_slave.sv */
`timescale 1ns/10ps
`include "waveform_defs.svh"

module spi_command_slave (
	input logic word_clock,
	input logic reset4_word_clock,
	input logic sck,
	input logic mosi,
	input logic ssel,
	output logic miso,
	output logic cmd_req,
	output waveform_pkg::command_t cmd_opcode,
	output logic [`SPI_ADDRESS_BITS-1:0] cmd_address,
	output logic [`SPI_DATA_BITS-1:0] cmd_data,
	input logic cmd_ack,
	input logic [`SPI_DATA_BITS-1:0] reply_data
);
	// first bit index of the data phase
	localparam int DATA_START = `SPI_FRAME_BITS - `SPI_DATA_BITS;

	waveform_pkg::spi_state_t state;
	logic [2:0] sck_pipe;
	logic [2:0] ssel_pipe;
	logic [1:0] mosi_pipe;
	logic [5:0] bit_count;
	logic [`SPI_FRAME_BITS-1:0] shift_reg;
	logic [`SPI_DATA_BITS-1:0] reply_shift;
	logic [`SPI_DATA_BITS-1:0] reply_latched;
	logic frame_pending;
	logic selected, sck_rise, sck_fall, ssel_fall, frame_valid, load_command;

	// ------------------------------------------------------------------
	// pin synchronizers and edge detect
	// ------------------------------------------------------------------

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			sck_pipe <= 3'b000;
			ssel_pipe <= 3'b111;
			mosi_pipe <= 2'b00;
		end else begin
			sck_pipe <= {sck_pipe[1:0], sck};
			ssel_pipe <= {ssel_pipe[1:0], ssel};
			mosi_pipe <= {mosi_pipe[0], mosi};
		end
	end

	assign selected = ~ssel_pipe[1];
	assign sck_rise = sck_pipe[1] & ~sck_pipe[2];
	assign sck_fall = ~sck_pipe[1] & sck_pipe[2];
	assign ssel_fall = ssel_pipe[2] & ~ssel_pipe[1];
	// only a full 56 bit frame counts
	assign frame_valid = ssel_pipe[1] & ~ssel_pipe[2] && bit_count == `SPI_FRAME_BITS;

	// bit counter saturates one past a full frame
	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			bit_count <= '0;
		end else if (ssel_fall) begin
			bit_count <= '0;
		end else if (selected && sck_rise && bit_count <= `SPI_FRAME_BITS) begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// mosi in on rising sck, reply out on falling sck
	always_ff @(posedge word_clock) begin
		if (selected && sck_rise) begin
			shift_reg <= {shift_reg[`SPI_FRAME_BITS-2:0], mosi_pipe[1]};
		end
		if (ssel_fall) begin
			reply_shift <= reply_latched;
		end else if (selected && sck_fall && bit_count > DATA_START
				&& bit_count <= `SPI_FRAME_BITS) begin
			reply_shift <= {reply_shift[`SPI_DATA_BITS-2:0], 1'b0};
		end
	end

	// zero during command and address phases
	assign miso = selected && bit_count >= DATA_START && reply_shift[`SPI_DATA_BITS-1];

	// ------------------------------------------------------------------
	// framing and request handshake
	// ------------------------------------------------------------------

	// a frame ending mid handshake waits for idle
	assign load_command = (state == waveform_pkg::spi_idle && (frame_pending || frame_valid))
		|| (state == waveform_pkg::spi_shifting && frame_valid);

	always_ff @(posedge word_clock) begin
		if (load_command) begin
			cmd_opcode <= waveform_pkg::command_t'(
				shift_reg[`SPI_FRAME_BITS-1 -: `SPI_COMMAND_BITS]);
			cmd_address <= shift_reg[`SPI_DATA_BITS +: `SPI_ADDRESS_BITS];
			cmd_data <= shift_reg[`SPI_DATA_BITS-1:0];
		end
	end

	always_ff @(posedge word_clock) begin
		if (reset4_word_clock) begin
			state <= waveform_pkg::spi_idle;
			frame_pending <= 1'b0;
			reply_latched <= '0;
		end else begin
			if (load_command) begin
				frame_pending <= 1'b0;
			end else if (frame_valid) begin
				frame_pending <= 1'b1;
			end
			case (state)
				waveform_pkg::spi_idle: begin
					if (load_command) begin
						state <= waveform_pkg::spi_requesting;
					end else if (ssel_fall) begin
						state <= waveform_pkg::spi_shifting;
					end
				end
				waveform_pkg::spi_shifting: begin
					if (load_command) begin
						state <= waveform_pkg::spi_requesting;
					end else if (ssel_pipe[1] & ~ssel_pipe[2]) begin
						// short or long frame, dropped
						state <= waveform_pkg::spi_idle;
					end
				end
				waveform_pkg::spi_requesting: begin
					if (cmd_ack) begin
						reply_latched <= reply_data;
						state <= waveform_pkg::spi_wait_release;
					end
				end
				default: begin
					if (!cmd_ack) begin
						state <= waveform_pkg::spi_idle;
					end
				end
			endcase
		end
	end

	assign cmd_req = (state == waveform_pkg::spi_requesting);

endmodule

/* rtl/waveform_pkg.sv */
package waveform_pkg;

	// ------------------------------------------------------------------
	// host command byte
	// ------------------------------------------------------------------

	// unlisted codes act as a no-op with a zero reply
	typedef enum logic [7:0] {
		cmd_write_reg = 8'h01,
		cmd_read_reg = 8'h02,
		cmd_write_mem = 8'h03,
		cmd_read_mem = 8'h04
	} command_t;

	// spi slave framing and handshake
	typedef enum logic [1:0] {
		spi_idle,
		spi_shifting,
		spi_requesting,
		spi_wait_release
	} spi_state_t;

	// playback address stepper
	typedef enum logic {
		seq_stopped,
		seq_playing
	} sequencer_state_t;

endpackage

/* rtl/waveform_defs.svh */
`ifndef WAVEFORM_DEFS_SVH
`define WAVEFORM_DEFS_SVH

// ----------------------------------------------------------------------
// waveform memory geometry
// ----------------------------------------------------------------------

// 1024 words of 32 bits
`define WAVE_WORD_ADDR_WIDTH 10
`define WAVE_WORD_WIDTH 32
// byte address into the same memory
`define WAVE_BYTE_ADDR_WIDTH 12
`define WAVE_SAMPLE_WIDTH 8

// ----------------------------------------------------------------------
// spi frame layout, msb first
// ----------------------------------------------------------------------

`define SPI_FRAME_BITS 56
`define SPI_COMMAND_BITS 8
`define SPI_ADDRESS_BITS 16
`define SPI_DATA_BITS 32

// register map, indexed by the low address bits
`define REG_START 2'd0
`define REG_END 2'd1
`define REG_ENABLE 2'd2
`define REG_PASS_COUNT 2'd3

`endif
